// File: src/arilla_pkg.sv
`default_nettype none

package arilla_pkg;

    // ------------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------------

    localparam int data_width     = 32;
    localparam int bytes_per_word = 4;
    localparam int addr_width     = 30;  // Byte address minus the two lane bits.

    typedef logic [data_width-1:0]     data_t;
    typedef logic [bytes_per_word-1:0] byte_en_t;
    typedef logic [addr_width-1:0]     addr_t;

    // ------------------------------------------------------------------------
    // Request and response
    // ------------------------------------------------------------------------

    // One-cycle strobe from the master, 68 bits.
    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    address;
        byte_en_t byte_enable;
        data_t    wdata;
    } bus_req_t;

    // Registered answer of one device, 33 bits.
    typedef struct packed {
        logic  valid;
        data_t rdata;
    } dev_rsp_t;

    // What the master sees, 34 bits.
    typedef struct packed {
        logic  valid;
        logic  error;
        data_t rdata;
    } bus_rsp_t;

    // ------------------------------------------------------------------------
    // Timer register map
    // ------------------------------------------------------------------------

    // Word offsets inside the timer window.
    typedef enum logic [1:0] {
        reg_count   = 2'd0,
        reg_compare = 2'd1,
        reg_status  = 2'd2,
        reg_control = 2'd3
    } timer_reg_e;

endpackage

`default_nettype wire

// File: src/bus_memory.sv
`timescale 1ns/1ns
`default_nettype none

module bus_memory #(
    parameter int base_address = 0,
    parameter int size_bytes   = 4096
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  arilla_pkg::bus_req_t req,
    output logic                 hit,
    output arilla_pkg::dev_rsp_t rsp
);
    localparam int addr_width   = $bits(arilla_pkg::addr_t);
    localparam int size_words   = size_bytes / arilla_pkg::bytes_per_word;
    localparam int local_width  = $clog2(size_words);
    localparam int device_width = addr_width - local_width;

    // Window number of this device in the upper address bits.
    localparam logic [device_width-1:0] window = device_width'(base_address / size_bytes);

    logic [device_width-1:0] device_address;
    logic [local_width-1:0]  local_address;
    logic                    write_hit;
    logic                    read_hit;

    arilla_pkg::data_t mem [size_words];
    arilla_pkg::data_t rd_data;
    logic              rd_valid;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    assign device_address = req.address[addr_width-1:local_width];
    assign local_address  = req.address[local_width-1:0];

    assign hit       = device_address == window;
    assign write_hit = hit && req.write;
    assign read_hit  = hit && req.read;

    // ------------------------------------------------------------------------
    // Storage and read port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (write_hit) begin
            for (int i = 0; i < arilla_pkg::bytes_per_word; i++) begin
                if (req.byte_enable[i]) begin
                    mem[local_address][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_hit) begin
            rd_data <= mem[local_address];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read_hit;
        end
    end

    assign rsp = '{valid: rd_valid, rdata: rd_data};

    assert property (@(posedge clk) disable iff (!rst_n) !(req.read && req.write));
    assert property (@(posedge clk) (size_bytes & (size_bytes - 1)) == 0);
    assert property (@(posedge clk) (base_address % size_bytes) == 0);  // Window alignment.

endmodule

`default_nettype wire

// File: src/bus_timer.sv
`timescale 1ns/1ns
`default_nettype none

module bus_timer #(
    parameter int base_address = 32'h2000
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  arilla_pkg::bus_req_t req,
    output logic                 hit,
    output arilla_pkg::dev_rsp_t rsp,
    output logic                 irq
);
    localparam int addr_width   = $bits(arilla_pkg::addr_t);
    localparam int n_regs       = 4;
    localparam int local_width  = $clog2(n_regs);
    localparam int device_width = addr_width - local_width;
    localparam int window_bytes = n_regs * arilla_pkg::bytes_per_word;

    localparam logic [device_width-1:0] window = device_width'(base_address / window_bytes);

    arilla_pkg::timer_reg_e offset;
    arilla_pkg::data_t      count;
    arilla_pkg::data_t      compare;
    arilla_pkg::data_t      rd_data;
    logic                   enable;
    logic                   match;
    logic                   rd_valid;
    logic                   write_hit;
    logic                   read_hit;

    // Applies the request byte lanes on top of a register value.
    function automatic arilla_pkg::data_t merge(arilla_pkg::data_t old_value);
        arilla_pkg::data_t result;
        result = old_value;
        for (int i = 0; i < arilla_pkg::bytes_per_word; i++) begin
            if (req.byte_enable[i]) begin
                result[8*i +: 8] = req.wdata[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign hit       = req.address[addr_width-1:local_width] == window;
    assign offset    = arilla_pkg::timer_reg_e'(req.address[local_width-1:0]);
    assign write_hit = hit && req.write;
    assign read_hit  = hit && req.read;

    // ------------------------------------------------------------------------
    // Counter, compare and control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= '0;
            compare <= '0;
            enable  <= 1'b0;
            match   <= 1'b0;
        end else begin
            if (write_hit && offset == arilla_pkg::reg_count) begin
                count <= merge(count);
            end else if (enable) begin
                count <= count + 1'b1;
            end
            if (write_hit && offset == arilla_pkg::reg_compare) begin
                compare <= merge(compare);
            end
            if (write_hit && offset == arilla_pkg::reg_control && req.byte_enable[0]) begin
                enable <= req.wdata[0];
            end
            if (enable && count == compare) begin
                match <= 1'b1;  // Sticky, a new match wins over a clear.
            end else if (write_hit && offset == arilla_pkg::reg_status &&
                         req.byte_enable[0] && req.wdata[0]) begin
                match <= 1'b0;
            end
        end
    end

    assign irq = match;

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (read_hit) begin
            case (offset)
                arilla_pkg::reg_count:   rd_data <= count;
                arilla_pkg::reg_compare: rd_data <= compare;
                arilla_pkg::reg_status:  rd_data <= {31'd0, match};
                default:                 rd_data <= {31'd0, enable};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read_hit;
        end
    end

    assign rsp = '{valid: rd_valid, rdata: rd_data};

    // A match is only taken with the counter enabled.
    assert property (@(posedge clk) disable iff (!rst_n) $rose(irq) |-> $past(enable));

endmodule

`default_nettype wire

// File: src/bus_response_collector.sv
`timescale 1ns/1ns
`default_nettype none

module bus_response_collector #(
    parameter int n_devices = 3
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  arilla_pkg::bus_req_t                 req,
    input  wire  [n_devices-1:0]                 hits,
    input  arilla_pkg::dev_rsp_t [n_devices-1:0] dev_rsp,
    output arilla_pkg::bus_rsp_t                 rsp
);
    logic              err_pending;
    logic [n_devices-1:0] valids;
    arilla_pkg::data_t    sel_data;

    // ------------------------------------------------------------------------
    // Unclaimed strobes
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_pending <= 1'b0;
        end else begin
            err_pending <= (req.read || req.write) && !(|hits);
        end
    end

    // ------------------------------------------------------------------------
    // Response select
    // ------------------------------------------------------------------------

    always_comb begin
        sel_data = '0;
        for (int i = 0; i < n_devices; i++) begin
            valids[i] = dev_rsp[i].valid;
            if (dev_rsp[i].valid) begin
                sel_data = sel_data | dev_rsp[i].rdata;  // One-hot, so OR is a mux.
            end
        end
    end

    // Error responses carry zero data since no device answers them.
    assign rsp = '{
        valid: (|valids) || err_pending,
        error: err_pending,
        rdata: sel_data
    };

    // Windows do not overlap, so devices never answer together.
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(valids));

endmodule

`default_nettype wire

// File: src/arilla_system.sv
`timescale 1ns/1ns
`default_nettype none

module arilla_system #(
    parameter int ram0_base  = 32'h0000,
    parameter int ram0_bytes = 4096,
    parameter int ram1_base  = 32'h1000,
    parameter int ram1_bytes = 1024,
    parameter int timer_base = 32'h2000
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  arilla_pkg::bus_req_t req,
    output arilla_pkg::bus_rsp_t rsp,
    output logic                 irq
);
    localparam int n_devices = 3;

    logic                 [n_devices-1:0] hits;
    arilla_pkg::dev_rsp_t [n_devices-1:0] dev_rsp;

    // ------------------------------------------------------------------------
    // Devices
    // ------------------------------------------------------------------------

    bus_memory #(
        .base_address(ram0_base),
        .size_bytes  (ram0_bytes)
    ) u_ram0 (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .hit  (hits[0]),
        .rsp  (dev_rsp[0])
    );

    bus_memory #(
        .base_address(ram1_base),
        .size_bytes  (ram1_bytes)
    ) u_ram1 (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .hit  (hits[1]),
        .rsp  (dev_rsp[1])
    );

    bus_timer #(
        .base_address(timer_base)
    ) u_timer (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .hit  (hits[2]),
        .rsp  (dev_rsp[2]),
        .irq  (irq)
    );

    // ------------------------------------------------------------------------
    // Response path
    // ------------------------------------------------------------------------

    bus_response_collector #(
        .n_devices(n_devices)
    ) u_collector (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .hits   (hits),
        .dev_rsp(dev_rsp),
        .rsp    (rsp)
    );

endmodule

`default_nettype wire

// File: sim/tb_arilla_system.sv
`timescale 1ns/1ns
`default_nettype none

module tb_arilla_system;

    typedef enum logic [1:0] {
        op_idle  = 2'd0,
        op_write = 2'd1,
        op_read  = 2'd2,
        op_irq   = 2'd3
    } op_e;

    // One table entry. Idle uses wdata as its cycle count and irq checks rdata[0].
    typedef struct packed {
        op_e         kind;
        logic [31:0] byte_addr;
        logic [3:0]  byte_enable;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        error;
    } op_t;

    localparam int          sweep_len  = 32;
    localparam logic [31:0] timer_base = 32'h2000;

    logic                 clk;
    logic                 rst_n;
    arilla_pkg::bus_req_t req;
    arilla_pkg::bus_rsp_t rsp;
    logic                 irq;

    op_t               ops[$];
    arilla_pkg::data_t shadow [logic [31:0]];
    logic [31:0]       lfsr = 32'h0afa_2e86;
    int                errors = 0;
    int                checks = 0;
    int                cycle_count = 0;
    int                cycle_limit = 0;
    int                table_cycles = 0;

    // Response expected at the next sample point.
    logic              exp_valid;
    logic              exp_error;
    logic              exp_has_data;
    arilla_pkg::data_t exp_rdata;

    arilla_system UUT (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .rsp  (rsp),
        .irq  (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_limit != 0 && cycle_count >= cycle_limit);
        $display("Timeout: no end of test within %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Taps 32, 22, 2, 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    // Byte address of one timer register.
    function automatic logic [31:0] timer_addr(input arilla_pkg::timer_reg_e r);
        return timer_base + (32'(r) << 2);
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic add_op(input op_e kind, input logic [31:0] byte_addr,
                          input logic [3:0] byte_enable, input logic [31:0] wdata,
                          input logic [31:0] rdata, input logic error);
        ops.push_back('{kind, byte_addr, byte_enable, wdata, rdata, error});
        table_cycles += (kind == op_idle) ? int'(wdata) : 1;
    endtask

    task automatic build_table();
        logic [31:0] count_addr;
        logic [31:0] compare_addr;
        logic [31:0] status_addr;
        logic [31:0] control_addr;
        count_addr   = timer_addr(arilla_pkg::reg_count);
        compare_addr = timer_addr(arilla_pkg::reg_compare);
        status_addr  = timer_addr(arilla_pkg::reg_status);
        control_addr = timer_addr(arilla_pkg::reg_control);
        add_op(op_irq,   32'h0000, 4'h0, 32'd0,        32'd0,        1'b0);
        // RAM boundary words.
        add_op(op_write, 32'h0000, 4'hf, 32'h1111_0000, 32'd0,        1'b0);
        add_op(op_read,  32'h0000, 4'h0, 32'd0,        32'h1111_0000, 1'b0);
        add_op(op_write, 32'h0ffc, 4'hf, 32'ha5a5_0ffc, 32'd0,        1'b0);
        add_op(op_read,  32'h0ffc, 4'h0, 32'd0,        32'ha5a5_0ffc, 1'b0);
        add_op(op_write, 32'h1000, 4'hf, 32'h5a5a_1000, 32'd0,        1'b0);
        add_op(op_read,  32'h1000, 4'h0, 32'd0,        32'h5a5a_1000, 1'b0);
        add_op(op_write, 32'h13fc, 4'hf, 32'hc3c3_13fc, 32'd0,        1'b0);
        add_op(op_read,  32'h13fc, 4'h0, 32'd0,        32'hc3c3_13fc, 1'b0);
        // Byte lanes.
        add_op(op_write, 32'h0040, 4'hf, 32'h1122_3344, 32'd0,        1'b0);
        add_op(op_write, 32'h0040, 4'h1, 32'hdead_be99, 32'd0,        1'b0);
        add_op(op_write, 32'h0040, 4'h8, 32'h7700_0000, 32'd0,        1'b0);
        add_op(op_read,  32'h0040, 4'h0, 32'd0,        32'h7722_3399, 1'b0);
        add_op(op_write, 32'h1040, 4'hf, 32'hcafe_f00d, 32'd0,        1'b0);
        add_op(op_write, 32'h1040, 4'h6, 32'h0012_3400, 32'd0,        1'b0);
        add_op(op_read,  32'h1040, 4'h0, 32'd0,        32'hca12_340d, 1'b0);
        // Same word index in both RAMs.
        add_op(op_write, 32'h0080, 4'hf, 32'h0a0a_0a0a, 32'd0,        1'b0);
        add_op(op_write, 32'h1080, 4'hf, 32'h1b1b_1b1b, 32'd0,        1'b0);
        add_op(op_read,  32'h0080, 4'h0, 32'd0,        32'h0a0a_0a0a, 1'b0);
        add_op(op_read,  32'h1080, 4'h0, 32'd0,        32'h1b1b_1b1b, 1'b0);
        // Unmapped.
        add_op(op_read,  32'h3000, 4'h0, 32'd0,        32'd0,        1'b1);
        add_op(op_write, 32'h3000, 4'hf, 32'h0bad_0bad, 32'd0,        1'b1);
        // Timer.
        add_op(op_write, compare_addr, 4'hf, 32'd20,   32'd0,        1'b0);
        add_op(op_write, control_addr, 4'hf, 32'd1,    32'd0,        1'b0);
        add_op(op_idle,  32'h0000,     4'h0, 32'd40,   32'd0,        1'b0);
        add_op(op_irq,   32'h0000,     4'h0, 32'd0,    32'd1,        1'b0);
        add_op(op_read,  status_addr,  4'h0, 32'd0,    32'd1,        1'b0);
        add_op(op_write, status_addr,  4'hf, 32'd1,    32'd0,        1'b0);
        add_op(op_irq,   32'h0000,     4'h0, 32'd0,    32'd0,        1'b0);
        add_op(op_read,  status_addr,  4'h0, 32'd0,    32'd0,        1'b0);
        add_op(op_write, control_addr, 4'hf, 32'd0,    32'd0,        1'b0);
        add_op(op_read,  control_addr, 4'h0, 32'd0,    32'd0,        1'b0);
        add_op(op_write, count_addr,   4'hf, 32'h0000_1234, 32'd0,    1'b0);
        add_op(op_idle,  32'h0000,     4'h0, 32'd5,    32'd0,        1'b0);
        add_op(op_read,  count_addr,   4'h0, 32'd0,    32'h0000_1234, 1'b0);
    endtask

    // Back-to-back random writes, then reads of the same words.
    task automatic add_sweep();
        logic [31:0] addrs [sweep_len];
        logic [31:0] data;
        logic [31:0] pick;
        for (int i = 0; i < sweep_len; i++) begin
            pick = lfsr_bits(1);
            if (pick == 32'd0) begin
                addrs[i] = 32'h0000 + (lfsr_bits(10) << 2);
            end else begin
                addrs[i] = 32'h1000 + (lfsr_bits(8) << 2);
            end
            data = lfsr_bits(32);
            shadow[addrs[i]] = data;  // Last write wins.
            add_op(op_write, addrs[i], 4'hf, data, 32'd0, 1'b0);
        end
        for (int i = 0; i < sweep_len; i++) begin
            add_op(op_read, addrs[i], 4'h0, 32'd0, shadow[addrs[i]], 1'b0);
        end
    endtask

    task automatic drive_idle();
        req          = '0;
        exp_valid    = 1'b0;
        exp_error    = 1'b0;
        exp_has_data = 1'b0;
        exp_rdata    = '0;
    endtask

    task automatic drive_op(input op_t op);
        req             = '0;
        req.read        = op.kind == op_read;
        req.write       = op.kind == op_write;
        req.address     = op.byte_addr[31:2];
        req.byte_enable = op.byte_enable;
        req.wdata       = op.wdata;
        exp_valid       = req.read || op.error;  // Writes answer only when unclaimed.
        exp_error       = op.error;
        exp_has_data    = req.read;
        exp_rdata       = op.rdata;
    endtask

    // Samples the response to the request of the previous cycle.
    task automatic next_cycle();
        @(posedge clk);
        #5;
        compare("rsp.valid", 32'(rsp.valid), 32'(exp_valid));
        compare("rsp.error", 32'(rsp.error), 32'(exp_error));
        if (exp_has_data) begin
            compare("rsp.rdata", rsp.rdata, exp_rdata);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        op_t op;
        rst_n = 1'b0;
        drive_idle();
        build_table();
        add_sweep();
        cycle_limit = table_cycles + 20;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        foreach (ops[i]) begin
            op = ops[i];
            if (op.kind == op_idle) begin
                repeat (op.wdata) begin
                    next_cycle();
                    drive_idle();
                end
            end else if (op.kind == op_irq) begin
                next_cycle();
                compare("irq", 32'(irq), op.rdata);
                drive_idle();
            end else begin
                next_cycle();
                drive_op(op);
            end
        end
        next_cycle();
        drive_idle();
        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/arilla_pkg.sv
src/bus_memory.sv
src/bus_timer.sv
src/bus_response_collector.sv
src/arilla_system.sv
sim/tb_arilla_system.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_arilla_system \
    -o tb_sim -f tb.f || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && exit 0 || exit 1
